/* logic/id_pkg.sv */
package id_pkg;

    parameter int NUM_LANES = 2;
    parameter int XLEN      = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [2:0] {
        ALU_NOP = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4
    } alu_op_e;

    // one slot of the instruction queue
    typedef struct packed {
        word_t pc;
        word_t inst;
    } queue_entry_t;

    // content of one issued lane
    typedef struct packed {
        alu_op_e   op;
        word_t     src_a;
        word_t     src_b;
        reg_addr_t dest;
        logic      we;
        word_t     pc;
    } issue_t;

    // major opcodes
    parameter logic [5:0] OP_SPECIAL = 6'h00;
    parameter logic [5:0] OP_ADDIU   = 6'h09;
    parameter logic [5:0] OP_ORI     = 6'h0d;

    // funct field of SPECIAL
    parameter logic [5:0] FN_ADDU = 6'h21;
    parameter logic [5:0] FN_SUBU = 6'h23;
    parameter logic [5:0] FN_AND  = 6'h24;
    parameter logic [5:0] FN_OR   = 6'h25;

endpackage

/* logic/id_ifs.sv */
`timescale 1ns/1ps

// decoded lane towards the issue controller
interface decode_if import id_pkg::*; ();
    logic      valid;
    issue_t    iss;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      rs_used;
    logic      rt_used;

    modport lane (output valid, iss, rs, rt, rs_used, rt_used);
    modport ctrl (input  valid, iss, rs, rt, rs_used, rt_used);
endinterface

// two read ports of the register file, one lane
interface rf_read_if import id_pkg::*; ();
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    word_t     rdata_a;
    word_t     rdata_b;

    modport client (
        output raddr_a,
        output raddr_b,
        input  rdata_a,
        input  rdata_b
    );
    modport server (
        input  raddr_a,
        input  raddr_b,
        output rdata_a,
        output rdata_b
    );
endinterface

/* logic/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue import id_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push_i,
    input  logic                 push_two_i,
    input  queue_entry_t         push_entry_i [NUM_LANES],
    input  logic [1:0]           pop_count_i,
    output queue_entry_t         head_o [NUM_LANES],
    output logic [NUM_LANES-1:0] head_valid_o,
    output logic                 full_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    queue_entry_t     mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic [1:0]       push_n;

    // full when there is no room for a whole pair
    assign full_o  = count > CNT_W'(QUEUE_DEPTH - NUM_LANES);
    assign push_ok = push_i && !full_o;

    always_comb begin
        push_n = 2'd0;
        if (push_ok) begin
            push_n = push_two_i ? 2'd2 : 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(pop_count_i);   // wraps, depth is a power of two
            wr_ptr <= wr_ptr + PTR_W'(push_n);
            count  <= count + CNT_W'(push_n) - CNT_W'(pop_count_i);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (i < int'(push_n)) begin
                mem[wr_ptr + PTR_W'(i)] <= push_entry_i[i];
            end
        end
    end

    // oldest entry on lane 0
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_head
        assign head_o[g]       = mem[rd_ptr + PTR_W'(g)];
        assign head_valid_o[g] = count > CNT_W'(g);
    end

endmodule

/* logic/lane_decode.sv */
`timescale 1ns/1ps

module lane_decode import id_pkg::*; (
    input  queue_entry_t    entry_i,
    input  logic            valid_i,
    rf_read_if.client       rf,
    decode_if.lane          dec
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] imm;
    word_t       imm_sext;
    word_t       imm_zext;

    assign opcode = entry_i.inst[31:26];
    assign rs     = entry_i.inst[25:21];
    assign rt     = entry_i.inst[20:16];
    assign rd     = entry_i.inst[15:11];
    assign funct  = entry_i.inst[5:0];
    assign imm    = entry_i.inst[15:0];

    assign imm_sext = {{(XLEN-16){imm[15]}}, imm};
    assign imm_zext = {{(XLEN-16){1'b0}}, imm};

    // both fields always go to the register file
    assign rf.raddr_a = rs;
    assign rf.raddr_b = rt;

    assign dec.valid = valid_i;
    assign dec.rs    = rs;
    assign dec.rt    = rt;

    always_comb begin
        dec.iss       = '0;
        dec.iss.op    = ALU_NOP;
        dec.iss.src_a = rf.rdata_a;
        dec.iss.src_b = rf.rdata_b;
        dec.iss.pc    = entry_i.pc;
        dec.rs_used   = 1'b0;
        dec.rt_used   = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU: dec.iss.op = ALU_ADD;
                    FN_SUBU: dec.iss.op = ALU_SUB;
                    FN_AND:  dec.iss.op = ALU_AND;
                    FN_OR:   dec.iss.op = ALU_OR;
                    default: dec.iss.op = ALU_NOP;  // shifts etc. not handled
                endcase
                if (dec.iss.op != ALU_NOP) begin
                    dec.iss.we   = 1'b1;
                    dec.iss.dest = rd;
                    dec.rs_used  = 1'b1;
                    dec.rt_used  = 1'b1;
                end
            end
            OP_ADDIU: begin
                dec.iss.op    = ALU_ADD;
                dec.iss.we    = 1'b1;
                dec.iss.dest  = rt;
                dec.iss.src_b = imm_sext;
                dec.rs_used   = 1'b1;
            end
            OP_ORI: begin
                dec.iss.op    = ALU_OR;
                dec.iss.we    = 1'b1;
                dec.iss.dest  = rt;
                dec.iss.src_b = imm_zext;   // logical op, no sign
                dec.rs_used   = 1'b1;
            end
            default: begin
                dec.iss.op = ALU_NOP;
            end
        endcase
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file import id_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_LANES-1:0] wb_we_i,
    input  reg_addr_t            wb_waddr_i [NUM_LANES],
    input  word_t                wb_wdata_i [NUM_LANES],
    rf_read_if.server            rd [NUM_LANES]
);

    word_t regs [32];

    // write-first read, last port wins on a shared index
    function automatic word_t fwd_read(
        input reg_addr_t            addr,
        input word_t                stored,
        input logic [NUM_LANES-1:0] we,
        input reg_addr_t            waddr [NUM_LANES],
        input word_t                wdata [NUM_LANES]
    );
        word_t val;
        val = stored;
        for (int p = 0; p < NUM_LANES; p++) begin
            if (we[p] && waddr[p] == addr) begin
                val = wdata[p];
            end
        end
        if (addr == '0) begin
            val = '0;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_LANES; p++) begin
                if (wb_we_i[p] && wb_waddr_i[p] != '0) begin
                    regs[wb_waddr_i[p]] <= wb_wdata_i[p];   // higher port overrides
                end
            end
        end
    end

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_read
        assign rd[g].rdata_a = fwd_read(rd[g].raddr_a, regs[rd[g].raddr_a],
                                        wb_we_i, wb_waddr_i, wb_wdata_i);
        assign rd[g].rdata_b = fwd_read(rd[g].raddr_b, regs[rd[g].raddr_b],
                                        wb_we_i, wb_waddr_i, wb_wdata_i);
    end

endmodule

/* logic/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl import id_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall_i,
    decode_if.ctrl               dec [NUM_LANES],
    output logic [1:0]           pop_count_o,
    output logic [NUM_LANES-1:0] issue_valid_o,
    output issue_t               issue_o [NUM_LANES]
);

    issue_t               lane_iss [NUM_LANES];
    reg_addr_t            lane_rs [NUM_LANES];
    reg_addr_t            lane_rt [NUM_LANES];
    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] rs_used;
    logic [NUM_LANES-1:0] rt_used;
    logic                 older_writes;
    logic                 hazard;
    logic                 dual;
    logic [NUM_LANES-1:0] issue_sel;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign lane_iss[g]   = dec[g].iss;
        assign lane_rs[g]    = dec[g].rs;
        assign lane_rt[g]    = dec[g].rt;
        assign lane_valid[g] = dec[g].valid;
        assign rs_used[g]    = dec[g].rs_used;
        assign rt_used[g]    = dec[g].rt_used;
    end

    // r0 as dest never blocks
    assign older_writes = lane_iss[0].we && lane_iss[0].dest != '0;

    assign hazard = older_writes &&
                    ((rs_used[1] && lane_rs[1] == lane_iss[0].dest) ||
                     (rt_used[1] && lane_rt[1] == lane_iss[0].dest));

    assign dual = lane_valid[0] && lane_valid[1] && !hazard;

    assign issue_sel[0] = lane_valid[0] && !stall_i;
    assign issue_sel[1] = dual && !stall_i;

    // entries retire on the same edge they are registered
    assign pop_count_o = 2'(issue_sel[0]) + 2'(issue_sel[1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid_o <= '0;
        end else begin
            issue_valid_o <= issue_sel;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            issue_o[i] <= lane_iss[i];
        end
    end

endmodule

/* logic/id_stage.sv */
`timescale 1ns/1ps

module id_stage import id_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst,

    // fetch side
    input  logic                 fetch_valid_i,
    input  word_t                fetch_pc_i,
    input  word_t                fetch_inst0_i,
    input  word_t                fetch_inst1_i,
    input  logic                 fetch_pair_i,
    output logic                 queue_full_o,

    input  logic                 stall_i,

    // write-back ports
    input  logic [NUM_LANES-1:0] wb_we_i,
    input  reg_addr_t            wb_waddr_i [NUM_LANES],
    input  word_t                wb_wdata_i [NUM_LANES],

    output logic [NUM_LANES-1:0] issue_valid_o,
    output issue_t               issue_o [NUM_LANES]
);

    queue_entry_t         push_entry [NUM_LANES];
    queue_entry_t         head [NUM_LANES];
    logic [NUM_LANES-1:0] head_valid;
    logic [1:0]           pop_count;

    decode_if  dec_if [NUM_LANES] ();
    rf_read_if rf_if [NUM_LANES] ();

    // second word of the pair sits one slot later
    assign push_entry[0] = '{pc: fetch_pc_i, inst: fetch_inst0_i};
    assign push_entry[1] = '{pc: fetch_pc_i + 32'd4, inst: fetch_inst1_i};

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_queue (
        .clk          (clk),
        .rst          (rst),
        .push_i       (fetch_valid_i),
        .push_two_i   (fetch_pair_i),
        .push_entry_i (push_entry),
        .pop_count_i  (pop_count),
        .head_o       (head),
        .head_valid_o (head_valid),
        .full_o       (queue_full_o)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        lane_decode i_lane (
            .entry_i (head[g]),
            .valid_i (head_valid[g]),
            .rf      (rf_if[g]),
            .dec     (dec_if[g])
        );
    end

    reg_file i_rf (
        .clk        (clk),
        .rst        (rst),
        .wb_we_i    (wb_we_i),
        .wb_waddr_i (wb_waddr_i),
        .wb_wdata_i (wb_wdata_i),
        .rd         (rf_if)
    );

    issue_ctrl i_issue (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall_i),
        .dec           (dec_if),
        .pop_count_o   (pop_count),
        .issue_valid_o (issue_valid_o),
        .issue_o       (issue_o)
    );

endmodule

/* dv/id_stage_assert.sv */
`timescale 1ns/1ps

module id_stage_assert import id_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input logic                         clk,
    input logic                         rst,
    input logic                         stall_i,
    input logic                         queue_full_o,
    input logic [1:0]                   pop_count,
    input logic [$clog2(QUEUE_DEPTH):0] queue_count,
    input logic [NUM_LANES-1:0]         issue_valid_o
);

    int fail_count = 0;

    // lane 1 only ever carries the younger half of a pair
    a_lane1_needs_lane0: assert property (@(posedge clk) disable iff (rst)
        issue_valid_o[1] |-> issue_valid_o[0])
        else begin
            fail_count++;
            $error("lane 1 issued without lane 0");
        end

    a_stall_clears_issue: assert property (@(posedge clk) disable iff (rst)
        stall_i |=> issue_valid_o == '0)
        else begin
            fail_count++;
            $error("issue valid set in the cycle after stall");
        end

    // while full only pops may change the count
    a_full_drops_push: assert property (@(posedge clk) disable iff (rst)
        queue_full_o |=> queue_count == $past(queue_count) - $past(pop_count))
        else begin
            fail_count++;
            $error("queue accepted a push while full");
        end

endmodule

bind id_stage id_stage_assert #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) i_assert (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall_i),
    .queue_full_o  (queue_full_o),
    .pop_count     (pop_count),
    .queue_count   (i_queue.count),
    .issue_valid_o (issue_valid_o)
);

/* dv/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb import id_pkg::*; ();

    localparam int TIMEOUT = 20;

    typedef struct {
        string                name;
        word_t                inst0;
        word_t                inst1;
        logic                 pair;
        logic [NUM_LANES-1:0] we;
        reg_addr_t            waddr0;
        word_t                wdata0;
        reg_addr_t            waddr1;
        word_t                wdata1;
        logic                 dual;
    } test_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 fetch_valid;
    word_t                fetch_pc;
    word_t                fetch_inst0;
    word_t                fetch_inst1;
    logic                 fetch_pair;
    logic                 queue_full;
    logic                 stall;
    logic [NUM_LANES-1:0] wb_we;
    reg_addr_t            wb_waddr [NUM_LANES];
    word_t                wb_wdata [NUM_LANES];
    logic [NUM_LANES-1:0] issue_valid;
    issue_t               issue [NUM_LANES];

    test_t       tests[$];
    word_t       ref_regs [32];
    logic [15:0] lfsr = 16'd51916;
    int          test_errs;
    int          n_tests;
    int          n_failed;
    int          n_errors;

    always #50 clk = ~clk;

    id_stage #(
        .QUEUE_DEPTH (8)
    ) i_dut (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid_i (fetch_valid),
        .fetch_pc_i    (fetch_pc),
        .fetch_inst0_i (fetch_inst0),
        .fetch_inst1_i (fetch_inst1),
        .fetch_pair_i  (fetch_pair),
        .queue_full_o  (queue_full),
        .stall_i       (stall),
        .wb_we_i       (wb_we),
        .wb_waddr_i    (wb_waddr),
        .wb_wdata_i    (wb_wdata),
        .issue_valid_o (issue_valid),
        .issue_o       (issue)
    );

    // one step per bit taken
    function automatic word_t lfsr_word();
        word_t w;
        logic  b;
        w = '0;
        for (int i = 0; i < XLEN; i++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hB400 : 16'h0000);
            w    = {w[XLEN-2:0], b};
        end
        return w;
    endfunction

    function automatic word_t r_type(input logic [5:0] fn, input int rs, input int rt,
                                     input int rd);
        return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input int rs, input int rt,
                                     input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // port 1 applied last so it wins on a shared index
    function automatic void apply_wb(input logic [NUM_LANES-1:0] we, input reg_addr_t a0,
                                     input word_t d0, input reg_addr_t a1, input word_t d1);
        if (we[0] && a0 != 5'd0) ref_regs[a0] = d0;
        if (we[1] && a1 != 5'd0) ref_regs[a1] = d1;
    endfunction

    function automatic issue_t expect_issue(input word_t inst, input word_t pc);
        issue_t e;
        e.op    = ALU_NOP;
        e.we    = 1'b0;
        e.dest  = '0;
        e.pc    = pc;
        e.src_a = ref_regs[inst[25:21]];
        e.src_b = ref_regs[inst[20:16]];
        if (inst[31:26] == OP_SPECIAL && inst[5:0] inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR}) begin
            e.we   = 1'b1;
            e.dest = inst[15:11];
            case (inst[5:0])
                FN_ADDU: e.op = ALU_ADD;
                FN_SUBU: e.op = ALU_SUB;
                FN_AND:  e.op = ALU_AND;
                default: e.op = ALU_OR;
            endcase
        end else if (inst[31:26] == OP_ADDIU) begin
            e.op    = ALU_ADD;
            e.we    = 1'b1;
            e.dest  = inst[20:16];
            e.src_b = {{16{inst[15]}}, inst[15:0]};
        end else if (inst[31:26] == OP_ORI) begin
            e.op    = ALU_OR;
            e.we    = 1'b1;
            e.dest  = inst[20:16];
            e.src_b = {16'h0000, inst[15:0]};
        end
        return e;
    endfunction

    task automatic add_test(input string name, input word_t i0, input word_t i1,
                            input logic pair, input logic [NUM_LANES-1:0] we,
                            input int a0, input word_t d0, input int a1, input word_t d1,
                            input logic dual);
        test_t t;
        t = '{name, i0, i1, pair, we, 5'(a0), d0, 5'(a1), d1, dual};
        tests.push_back(t);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $finish;
    endtask

    task automatic wait_issue(input string name, output logic [NUM_LANES-1:0] got);
        int cycles;
        cycles = 0;
        got    = '0;
        while (got == '0) begin
            @(negedge clk);
            got = issue_valid;
            cycles++;
            if (got == '0 && cycles > TIMEOUT) begin
                abort_run({"no instruction issued within the timeout in test ", name});
            end
        end
    endtask

    task automatic check_valid(input string name, input logic [NUM_LANES-1:0] exp,
                               input logic [NUM_LANES-1:0] got);
        if (got != exp) begin
            $display("ERROR %s valid: expected %b, actual %b", name, exp, got);
            test_errs++;
        end
    endtask

    task automatic check_lane(input string name, input int lane, input issue_t exp);
        issue_t act;
        act = issue[lane];
        if (exp.op == ALU_NOP) begin   // a nop only defines op, we and pc
            act.src_a = exp.src_a;
            act.src_b = exp.src_b;
            act.dest  = exp.dest;
        end
        if (act != exp) begin
            $display("ERROR %s lane %0d: expected %h, actual %h", name, lane, exp, issue[lane]);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        n_errors += test_errs;
        if (test_errs == 0) begin
            $display("PASS %s", name);
        end else begin
            n_failed++;
            $display("FAIL %s, %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic run_stall_test();
        issue_t exp_q[$];
        issue_t exp;
        word_t  pc;
        word_t  i0;
        word_t  i1;
        int     pushes;
        int     cycles;
        pc     = 32'h0000_2000;
        pushes = 0;
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        while (!queue_full) begin
            if (pushes > TIMEOUT) begin
                abort_run("queue_full_o never rose while the stage was stalled");
            end
            i0 = i_type(OP_ORI, 1, 20 + 2 * pushes, 16'(pushes));
            i1 = i_type(OP_ORI, 2, 21 + 2 * pushes, 16'(pushes));
            exp_q.push_back(expect_issue(i0, pc));
            exp_q.push_back(expect_issue(i1, pc + 32'd4));
            @(posedge clk);
            fetch_valid <= 1'b1;
            fetch_pc    <= pc;
            fetch_inst0 <= i0;
            fetch_inst1 <= i1;
            fetch_pair  <= 1'b1;
            @(posedge clk);
            fetch_valid <= 1'b0;
            @(negedge clk);
            check_valid("stall_full_drain", '0, issue_valid);
            pushes++;
            pc = pc + 32'd8;
        end
        // a pair offered while full must be dropped
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_pc    <= pc;
        fetch_inst0 <= i_type(OP_ORI, 3, 30, 16'hdead);
        fetch_inst1 <= i_type(OP_ORI, 3, 31, 16'hbeef);
        fetch_pair  <= 1'b1;
        @(posedge clk);
        fetch_valid <= 1'b0;
        @(negedge clk);
        check_valid("stall_full_drain", '0, issue_valid);
        @(posedge clk);
        stall  <= 1'b0;
        cycles = 0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("stalled instructions did not drain within the timeout");
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (issue_valid[l] && exp_q.size() > 0) begin
                    exp = exp_q.pop_front();
                    check_lane("stall_full_drain", l, exp);
                end
            end
        end
        @(negedge clk);
        check_valid("stall_full_drain", '0, issue_valid);
        end_test("stall_full_drain");
    endtask

    initial begin
        word_t                pc;
        word_t                d0;
        word_t                d1;
        issue_t               exp0;
        issue_t               exp1;
        logic [NUM_LANES-1:0] got;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_inst0 = '0;
        fetch_inst1 = '0;
        fetch_pair  = 1'b0;
        stall       = 1'b0;
        wb_we       = '0;
        foreach (wb_waddr[p]) begin
            wb_waddr[p] = '0;
            wb_wdata[p] = '0;
        end
        foreach (ref_regs[r]) ref_regs[r] = '0;
        test_errs = 0;
        n_tests   = 0;
        n_failed  = 0;
        n_errors  = 0;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_valid("reset", '0, issue_valid);
        if (queue_full) begin
            $display("ERROR reset full: expected 0, actual %b", queue_full);
            test_errs++;
        end
        end_test("reset");

        // random preload, two registers per cycle
        for (int r = 1; r < 32; r += 2) begin
            d0 = lfsr_word();
            d1 = lfsr_word();
            @(posedge clk);
            wb_we       <= 2'b11;
            wb_waddr[0] <= 5'(r);
            wb_waddr[1] <= 5'(r + 1);
            wb_wdata[0] <= d0;
            wb_wdata[1] <= d1;
            apply_wb(2'b11, 5'(r), d0, 5'(r + 1), d1);
        end
        @(posedge clk);
        wb_we <= '0;

        add_test("dual_addu_subu", r_type(FN_ADDU, 1, 2, 3), r_type(FN_SUBU, 4, 5, 6),
                 1'b1, 2'b00, 0, '0, 0, '0, 1'b1);
        add_test("dep_pair", r_type(FN_ADDU, 1, 2, 7), r_type(FN_OR, 7, 3, 8),
                 1'b1, 2'b00, 0, '0, 0, '0, 1'b0);
        add_test("dest_r0_dual", r_type(FN_ADDU, 1, 2, 0), r_type(FN_AND, 0, 4, 11),
                 1'b1, 2'b00, 0, '0, 0, '0, 1'b1);
        add_test("imm_ext", i_type(OP_ADDIU, 1, 12, 16'hfffb), i_type(OP_ORI, 2, 13, 16'h8001),
                 1'b1, 2'b00, 0, '0, 0, '0, 1'b1);
        add_test("unknown_nop", 32'hfc00_0000, r_type(FN_ADDU, 5, 1, 16),
                 1'b1, 2'b00, 0, '0, 0, '0, 1'b1);
        add_test("wb_forward", r_type(FN_ADDU, 17, 18, 19), '0,
                 1'b0, 2'b01, 17, 32'hcafe_0017, 0, '0, 1'b0);
        add_test("wb_both_ports", r_type(FN_SUBU, 20, 21, 22), '0,
                 1'b0, 2'b11, 20, 32'h1111_0000, 20, 32'h2222_0000, 1'b0);

        foreach (tests[t]) begin
            pc = 32'h0000_1000 + 32'(t) * 32'h10;
            @(posedge clk);
            fetch_valid <= 1'b1;
            fetch_pc    <= pc;
            fetch_inst0 <= tests[t].inst0;
            fetch_inst1 <= tests[t].inst1;
            fetch_pair  <= tests[t].pair;
            @(posedge clk);
            fetch_valid <= 1'b0;
            wb_we       <= tests[t].we;   // lands in the decode cycle
            wb_waddr[0] <= tests[t].waddr0;
            wb_wdata[0] <= tests[t].wdata0;
            wb_waddr[1] <= tests[t].waddr1;
            wb_wdata[1] <= tests[t].wdata1;
            apply_wb(tests[t].we, tests[t].waddr0, tests[t].wdata0, tests[t].waddr1,
                     tests[t].wdata1);
            exp0 = expect_issue(tests[t].inst0, pc);
            exp1 = expect_issue(tests[t].inst1, pc + 32'd4);
            @(posedge clk);
            wb_we <= '0;
            wait_issue(tests[t].name, got);
            if (tests[t].pair && tests[t].dual) begin
                check_valid(tests[t].name, 2'b11, got);
                check_lane(tests[t].name, 0, exp0);
                check_lane(tests[t].name, 1, exp1);
            end else begin
                check_valid(tests[t].name, 2'b01, got);
                check_lane(tests[t].name, 0, exp0);
                if (tests[t].pair) begin
                    @(negedge clk);   // younger follows alone in the next cycle
                    got = issue_valid;
                    check_valid(tests[t].name, 2'b01, got);
                    check_lane(tests[t].name, 0, exp1);
                end
            end
            @(negedge clk);
            check_valid(tests[t].name, '0, issue_valid);
            end_test(tests[t].name);
        end

        run_stall_test();

        if (i_dut.i_assert.fail_count != 0) begin
            $display("%0d assertion failures", i_dut.i_assert.fail_count);
            n_errors += i_dut.i_assert.fail_count;
        end
        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* sim.f */
logic/id_pkg.sv
logic/id_ifs.sv
logic/inst_queue.sv
logic/lane_decode.sv
logic/reg_file.sv
logic/issue_ctrl.sv
logic/id_stage.sv
dv/id_stage_assert.sv
dv/id_stage_tb.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - logic/id_pkg.sv
  - logic/id_ifs.sv
  - logic/inst_queue.sv
  - logic/lane_decode.sv
  - logic/reg_file.sv
  - logic/issue_ctrl.sv
  - logic/id_stage.sv
  - target: simulation
    files:
      - dv/id_stage_assert.sv
      - dv/id_stage_tb.sv
